// File: list.f
+incdir+logic
logic/alu_pkg.sv
logic/alu_arith.sv
logic/alu_shifter.sv
logic/polar_lane.sv
logic/alu_top.sv
verif/alu_checker.sv
verif/alu_tb.sv

// File: verif/alu_tb.sv
// ------------------------------------------------
// Testbench for alu_top. Applies a table of requests
// one per clock and lets alu_checker compare the
// results. Ends with a count summary.
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module alu_tb;

    localparam int MAX_ENTRIES   = 48;
    localparam int RESET_CYCLES  = 4;
    localparam int GAP_AFTER     = 17;
    localparam int GAP_CYCLES    = 2;
    localparam int IDLE_CYCLES   = 4;
    localparam int MARGIN_CYCLES = 20;

    logic             clk;
    logic             arst_n;
    logic             valid;
    alu_pkg::alu_op_e op;
    alu_pkg::xlen_t   operand_a;
    alu_pkg::xlen_t   operand_b;
    alu_pkg::xlen_t   imm;
    logic             valid_out;
    alu_pkg::xlen_t   result_out;
    logic             branch_out;
    alu_pkg::xlen_t   exp_result;
    logic             exp_branch;
    logic [8*12-1:0]  exp_name;
    int               pass_cnt;
    int               fail_cnt;
    int               checked_cnt;
    int               n_entries = 0;
    int               cycle_cnt;
    int               idx;

    // Stimulus table
    alu_pkg::alu_op_e      tbl_op     [MAX_ENTRIES];
    logic [`ALU_XLEN-1:0]  tbl_a      [MAX_ENTRIES];
    logic [`ALU_XLEN-1:0]  tbl_b      [MAX_ENTRIES];
    logic [`ALU_XLEN-1:0]  tbl_imm    [MAX_ENTRIES];
    logic [`ALU_XLEN-1:0]  tbl_result [MAX_ENTRIES];
    logic                  tbl_branch [MAX_ENTRIES];
    logic [8*12-1:0]       tbl_name   [MAX_ENTRIES];

    alu_top alu_top_i (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .valid_i     (valid),
        .op_i        (op),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .imm_i       (imm),
        .valid_o     (valid_out),
        .result_o    (result_out),
        .branch_o    (branch_out)
    );

    alu_checker alu_checker_i (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .exp_valid_i   (valid),
        .exp_result_i  (exp_result),
        .exp_branch_i  (exp_branch),
        .exp_name_i    (exp_name),
        .dut_valid_i   (valid_out),
        .dut_result_i  (result_out),
        .dut_branch_i  (branch_out),
        .pass_cnt_o    (pass_cnt),
        .fail_cnt_o    (fail_cnt),
        .checked_cnt_o (checked_cnt)
    );

    task automatic add_polar(input alu_pkg::alu_op_e op_v, input logic [31:0] a_v,
                             input logic [31:0] b_v, input logic [31:0] imm_v,
                             input logic [31:0] res_v, input logic [8*12-1:0] name_v);
        tbl_op[n_entries]     = op_v;
        tbl_a[n_entries]      = a_v;
        tbl_b[n_entries]      = b_v;
        tbl_imm[n_entries]    = imm_v;
        tbl_result[n_entries] = res_v;
        tbl_branch[n_entries] = 1'b1;
        tbl_name[n_entries]   = name_v;
        n_entries++;
    endtask

    task automatic add_entry(input alu_pkg::alu_op_e op_v, input logic [31:0] a_v,
                             input logic [31:0] b_v, input logic [31:0] res_v,
                             input logic br_v, input logic [8*12-1:0] name_v);
        add_polar(op_v, a_v, b_v, 32'h0, res_v, name_v);
        tbl_branch[n_entries-1] = br_v;
    endtask

    task automatic load_table();
        // Add, subtract, logic
        add_entry(alu_pkg::OP_ADD, 32'hffffffff, 32'h00000001, 32'h00000000, 1'b1, "add_wrap");
        add_entry(alu_pkg::OP_ADD, 32'h12345678, 32'h11111111, 32'h23456789, 1'b1, "add_plain");
        add_entry(alu_pkg::OP_SUB, 32'h00000005, 32'h00000007, 32'hfffffffe, 1'b1, "sub_neg");
        add_entry(alu_pkg::OP_SUB, 32'h80000000, 32'h00000001, 32'h7fffffff, 1'b1, "sub_wrap");
        add_entry(alu_pkg::OP_AND, 32'hf0f0a5a5, 32'h0ff05a5a, 32'h00f00000, 1'b1, "and_mix");
        add_entry(alu_pkg::OP_OR,  32'hf0f0a5a5, 32'h0ff05a5a, 32'hfff0ffff, 1'b1, "or_mix");
        add_entry(alu_pkg::OP_XOR, 32'hf0f0a5a5, 32'h0ff05a5a, 32'hff00ffff, 1'b1, "xor_mix");
        // Shifts
        add_entry(alu_pkg::OP_SLL, 32'h80000001, 32'h00000000, 32'h80000001, 1'b1, "sll_0");
        add_entry(alu_pkg::OP_SLL, 32'h80000001, 32'h00000001, 32'h00000002, 1'b1, "sll_1");
        add_entry(alu_pkg::OP_SLL, 32'h00000001, 32'h0000001f, 32'h80000000, 1'b1, "sll_31");
        add_entry(alu_pkg::OP_SRL, 32'h12345678, 32'h00000000, 32'h12345678, 1'b1, "srl_0");
        add_entry(alu_pkg::OP_SRL, 32'h80000000, 32'h00000001, 32'h40000000, 1'b1, "srl_1");
        add_entry(alu_pkg::OP_SRL, 32'h80000000, 32'h0000001f, 32'h00000001, 1'b1, "srl_31");
        add_entry(alu_pkg::OP_SRA, 32'h80000000, 32'h00000000, 32'h80000000, 1'b1, "sra_0");
        add_entry(alu_pkg::OP_SRA, 32'h80000000, 32'h00000001, 32'hc0000000, 1'b1, "sra_1");
        add_entry(alu_pkg::OP_SRA, 32'h80000000, 32'h0000001f, 32'hffffffff, 1'b1, "sra_31");
        add_entry(alu_pkg::OP_SRA, 32'hf0000000, 32'h00000024, 32'hff000000, 1'b1, "sra_low5");
        add_entry(alu_pkg::OP_SRA, 32'h40000000, 32'h00000001, 32'h20000000, 1'b1, "sra_pos");
        // Set less than and branches
        add_entry(alu_pkg::OP_SLTS, 32'hffffffff, 32'h00000001, 32'h00000001, 1'b1, "slts_neg");
        add_entry(alu_pkg::OP_SLTU, 32'hffffffff, 32'h00000001, 32'h00000000, 1'b1, "sltu_neg");
        add_entry(alu_pkg::OP_EQ,  32'h00000005, 32'h00000005, 32'h00000000, 1'b1, "eq_true");
        add_entry(alu_pkg::OP_EQ,  32'h00000005, 32'h00000006, 32'h00000000, 1'b0, "eq_false");
        add_entry(alu_pkg::OP_NE,  32'h00000005, 32'h00000006, 32'h00000000, 1'b1, "ne_true");
        add_entry(alu_pkg::OP_NE,  32'h00000005, 32'h00000005, 32'h00000000, 1'b0, "ne_false");
        add_entry(alu_pkg::OP_LTS, 32'hffffffff, 32'h00000001, 32'h00000000, 1'b1, "lts_true");
        add_entry(alu_pkg::OP_LTS, 32'h00000005, 32'h00000005, 32'h00000000, 1'b0, "lts_equal");
        add_entry(alu_pkg::OP_LTU, 32'h00000001, 32'hffffffff, 32'h00000000, 1'b1, "ltu_true");
        add_entry(alu_pkg::OP_LTU, 32'hffffffff, 32'h00000001, 32'h00000000, 1'b0, "ltu_false");
        add_entry(alu_pkg::OP_GES, 32'h00000005, 32'h00000005, 32'h00000000, 1'b1, "ges_equal");
        add_entry(alu_pkg::OP_GES, 32'h80000000, 32'h7fffffff, 32'h00000000, 1'b0, "ges_false");
        add_entry(alu_pkg::OP_GEU, 32'h80000000, 32'h7fffffff, 32'h00000000, 1'b1, "geu_true");
        add_entry(alu_pkg::OP_GEU, 32'h00000003, 32'h00000004, 32'h00000000, 1'b0, "geu_false");
        // Polar lanes with byte 3 first in each word
        add_polar(alu_pkg::OP_PL_R, 32'h807fff01, 32'h010005ff, 32'h0,
                  32'h00000100, "r_b_one");
        add_polar(alu_pkg::OP_PL_R, 32'h80ff0081, 32'h00028001, 32'h0,
                  32'h01010000, "r_signs");
        add_polar(alu_pkg::OP_PL_DECODE, 32'h11223344, 32'h00ff0001, 32'h0,
                  32'h11003300, "dec_mix");
        add_polar(alu_pkg::OP_PL_DECODE, 32'h80ff7f01, 32'h00000000, 32'h0,
                  32'h80ff7f01, "dec_b_zero");
        add_polar(alu_pkg::OP_PL_F, 32'h05fc80f6, 32'hfd0410f9, 32'h0,
                  32'hfdfcf007, "f_mixed");
        add_polar(alu_pkg::OP_PL_F, 32'h80007f03, 32'h80857f80, 32'h0,
                  32'h80007ffd, "f_min128");
        add_polar(alu_pkg::OP_PL_G, 32'h7f801080, 32'h01ff2000, 32'h0,
                  32'h7f813081, "g_sum_sat");
        add_polar(alu_pkg::OP_PL_G, 32'h80057f03, 32'h7f068010, 32'h0100ff02,
                  32'h7f0b810d, "g_mixed");
        add_polar(alu_pkg::OP_PL_G, 32'h01020304, 32'h04030201, 32'h01010101,
                  32'h0301fffd, "g_diff");
    endtask

    task automatic drive_entry(input int idx_v);
        #1;
        valid      = 1'b1;
        op         = tbl_op[idx_v];
        operand_a  = tbl_a[idx_v];
        operand_b  = tbl_b[idx_v];
        imm        = tbl_imm[idx_v];
        exp_result = tbl_result[idx_v];
        exp_branch = tbl_branch[idx_v];
        exp_name   = tbl_name[idx_v];
        @(posedge clk);
    endtask

    task automatic drive_idle();
        #1;
        valid = 1'b0;
        @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------
    // Timeout from table length plus reset and margin
    // ------------------------------------------------
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < n_entries + RESET_CYCLES + MARGIN_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_cnt);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        arst_n     = 1'b0;
        valid      = 1'b0;
        op         = alu_pkg::OP_ADD;
        operand_a  = '0;
        operand_b  = '0;
        imm        = '0;
        exp_result = '0;
        exp_branch = 1'b1;
        exp_name   = '0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
        @(posedge clk);

        // Back-to-back strobes with one short gap
        for (idx = 0; idx < n_entries; idx++) begin
            if (idx == GAP_AFTER) begin
                repeat (GAP_CYCLES) drive_idle();
            end
            drive_entry(idx);
        end
        while (checked_cnt < n_entries) begin
            drive_idle();
        end
        repeat (IDLE_CYCLES) drive_idle();

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && checked_cnt == n_entries) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/alu_checker.sv
// ------------------------------------------------
// Scoreboard for alu_top. Takes the expected values
// on each strobe and compares the registered outputs
// one cycle later, on the falling edge.
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module alu_checker (
    input  wire                 clk_i,
    input  wire                 arst_n_i,
    input  wire                 exp_valid_i,
    input  wire [`ALU_XLEN-1:0] exp_result_i,
    input  wire                 exp_branch_i,
    input  wire [8*12-1:0]      exp_name_i,
    input  wire                 dut_valid_i,
    input  wire [`ALU_XLEN-1:0] dut_result_i,
    input  wire                 dut_branch_i,
    output int                  pass_cnt_o,
    output int                  fail_cnt_o,
    output int                  checked_cnt_o
);

    int                 pass_cnt = 0;
    int                 fail_cnt = 0;
    int                 checked_cnt = 0;
    logic               reset_seen = 1'b0;
    logic               test_ok;
    logic               pend;
    logic [`ALU_XLEN-1:0] pend_result;
    logic               pend_branch;
    logic [8*12-1:0]    pend_name;

    assign pass_cnt_o    = pass_cnt;
    assign fail_cnt_o    = fail_cnt;
    assign checked_cnt_o = checked_cnt;

    // One line per finished test
    task automatic record_test(input logic ok, input logic [8*12-1:0] name);
        if (ok) begin
            pass_cnt++;
            $display("test %0s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %0s: fail", name);
        end
    endtask

    // Expected values move one cycle along, like the DUT register
    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend        <= 1'b0;
            pend_result <= '0;
            pend_branch <= 1'b1;
            pend_name   <= '0;
        end else begin
            pend        <= exp_valid_i;
            pend_result <= exp_result_i;
            pend_branch <= exp_branch_i;
            pend_name   <= exp_name_i;
        end
    end

    // Outputs are stable half a cycle after the edge
    always @(negedge clk_i) begin
        if (arst_n_i) begin
            test_ok = 1'b1;
            if (!reset_seen) begin
                reset_seen = 1'b1;
                if (dut_valid_i !== 1'b0) begin
                    $display("valid_o is high in the first cycle after reset");
                    test_ok = 1'b0;
                end
                if (dut_result_i !== '0) begin
                    $display("error at %0t ns: result_o is %h, expected %h",
                             $time, dut_result_i, {`ALU_XLEN{1'b0}});
                    test_ok = 1'b0;
                end
                if (dut_branch_i !== 1'b1) begin
                    $display("error at %0t ns: branch_o is %b, expected 1", $time, dut_branch_i);
                    test_ok = 1'b0;
                end
                record_test(test_ok, "reset");
            end else if (pend) begin
                checked_cnt++;
                if (dut_valid_i !== 1'b1) begin
                    $display("valid_o missing one cycle after the strobe of %0s", pend_name);
                    test_ok = 1'b0;
                end else begin
                    if (dut_result_i !== pend_result) begin
                        $display("error at %0t ns: result_o is %h, expected %h",
                                 $time, dut_result_i, pend_result);
                        test_ok = 1'b0;
                    end
                    if (dut_branch_i !== pend_branch) begin
                        $display("error at %0t ns: branch_o is %b, expected %b",
                                 $time, dut_branch_i, pend_branch);
                        test_ok = 1'b0;
                    end
                end
                record_test(test_ok, pend_name);
            end else if (dut_valid_i !== 1'b0) begin
                $display("valid_o is high at %0t ns with no request pending", $time);
                fail_cnt++;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/alu_top.sv
// ------------------------------------------------
// Registered ALU top. A valid_i strobe takes one
// request; result_o, branch_o and a valid_o pulse
// follow one cycle later. No back-pressure.
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module alu_top (
    input  wire                   clk_i,
    input  wire                   arst_n_i,
    input  wire                   valid_i,
    input  wire alu_pkg::alu_op_e op_i,
    input  wire alu_pkg::xlen_t   operand_a_i,
    input  wire alu_pkg::xlen_t   operand_b_i,
    input  wire alu_pkg::xlen_t   imm_i,
    output logic                  valid_o,
    output alu_pkg::xlen_t        result_o,
    output logic                  branch_o
);

    alu_pkg::xlen_t                     sum;
    logic                               less;
    logic                               branch_res;
    alu_pkg::shamt_t                    shamt;
    alu_pkg::xlen_t                     shift_res;
    alu_pkg::xlen_t                     logic_res;
    alu_pkg::xlen_t                     slt_word;
    alu_pkg::lane_t [`POLAR_LANES-1:0]  lane_res;
    alu_pkg::xlen_t                     polar_word;
    alu_pkg::xlen_t                     result_d;

    // ------------------------------------------------
    // Functional units
    // ------------------------------------------------

    alu_arith alu_arith_i (
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .sum_o       (sum),
        .less_o      (less),
        .branch_o    (branch_res)
    );

    // Only the low 5 bits of b count
    assign shamt = operand_b_i[$bits(alu_pkg::shamt_t)-1:0];

    alu_shifter alu_shifter_i (
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .shamt_i     (shamt),
        .result_o    (shift_res)
    );

    // Lane k works on byte k of each input
    for (genvar k = 0; k < `POLAR_LANES; k++) begin : g_lane
        polar_lane polar_lane_i (
            .op_i     (op_i),
            .a_i      (operand_a_i[k*`POLAR_Q +: `POLAR_Q]),
            .b_i      (operand_b_i[k*`POLAR_Q +: `POLAR_Q]),
            .imm_i    (imm_i[k*`POLAR_Q +: `POLAR_Q]),
            .result_o (lane_res[k])
        );
    end

    assign polar_word = lane_res;

    // Bitwise logic
    always_comb begin
        case (op_i)
            alu_pkg::OP_OR:  logic_res = operand_a_i | operand_b_i;
            alu_pkg::OP_XOR: logic_res = operand_a_i ^ operand_b_i;
            default:         logic_res = operand_a_i & operand_b_i;
        endcase
    end

    assign slt_word = {{(`ALU_XLEN-1){1'b0}}, less};

    // ------------------------------------------------
    // Result select by operation class
    // ------------------------------------------------

    always_comb begin
        case (op_i)
            alu_pkg::OP_ADD, alu_pkg::OP_SUB: result_d = sum;
            alu_pkg::OP_AND, alu_pkg::OP_OR,
            alu_pkg::OP_XOR:                  result_d = logic_res;
            alu_pkg::OP_SLL, alu_pkg::OP_SRL,
            alu_pkg::OP_SRA:                  result_d = shift_res;
            alu_pkg::OP_SLTS, alu_pkg::OP_SLTU: result_d = slt_word;
            alu_pkg::OP_PL_R, alu_pkg::OP_PL_F,
            alu_pkg::OP_PL_DECODE,
            alu_pkg::OP_PL_G:                 result_d = polar_word;
            // Branches return only the condition
            default:                          result_d = '0;
        endcase
    end

    // ------------------------------------------------
    // Output register
    // ------------------------------------------------

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
            branch_o <= 1'b1;
        end else begin
            valid_o <= valid_i;
            // Hold the last result between strobes
            if (valid_i) begin
                result_o <= result_d;
                branch_o <= branch_res;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/polar_lane.sv
// ------------------------------------------------
// One signed 8-bit polar lane. Computes R, F,
// DECODE and G and returns the one selected by op.
// Non-polar operations give zero.
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module polar_lane (
    input  wire alu_pkg::alu_op_e op_i,
    input  wire alu_pkg::lane_t   a_i,
    input  wire alu_pkg::lane_t   b_i,
    input  wire alu_pkg::lane_t   imm_i,
    output alu_pkg::lane_t        result_o
);

    // Symmetric saturation limit, +/-127 for 8-bit lanes
    localparam int LANE_MAX = (1 << (`POLAR_Q - 1)) - 1;

    logic                      a_neg;
    logic                      b_neg;
    alu_pkg::lane_t            abs_a;
    alu_pkg::lane_t            abs_b;
    alu_pkg::lane_t            min_mag;
    logic signed [`POLAR_Q:0]  sum_ext;
    logic signed [`POLAR_Q:0]  diff_ext;
    alu_pkg::lane_t            func_r;
    alu_pkg::lane_t            func_f;
    alu_pkg::lane_t            func_decode;
    alu_pkg::lane_t            func_g;

    // Clamp a widened sum back into the lane range
    function automatic alu_pkg::lane_t sat_lane(input logic signed [`POLAR_Q:0] value);
        alu_pkg::lane_t clamped;
        if (value > LANE_MAX) begin
            clamped = alu_pkg::lane_t'(LANE_MAX);
        end else if (value < -LANE_MAX) begin
            clamped = alu_pkg::lane_t'(-LANE_MAX);
        end else begin
            clamped = value[`POLAR_Q-1:0];
        end
        return clamped;
    endfunction

    assign a_neg = a_i[`POLAR_Q-1];
    assign b_neg = b_i[`POLAR_Q-1];

    // ------------------------------------------------
    // R and DECODE
    // ------------------------------------------------

    // b == 1 forces zero, else the sign of a
    assign func_r = (b_i == alu_pkg::lane_t'(1)) ? '0 : {{(`POLAR_Q-1){1'b0}}, a_neg};

    assign func_decode = (b_i == '0) ? a_i : '0;

    // ------------------------------------------------
    // F, signed minimum of magnitudes
    // ------------------------------------------------

    // -128 stays 0x80, compared as unsigned 128
    assign abs_a = a_neg ? alu_pkg::lane_t'(-a_i) : a_i;
    assign abs_b = b_neg ? alu_pkg::lane_t'(-b_i) : b_i;

    // Ties keep the magnitude of a
    assign min_mag = (abs_a > abs_b) ? abs_b : abs_a;

    assign func_f = (a_neg ^ b_neg) ? alu_pkg::lane_t'(-min_mag) : min_mag;

    // ------------------------------------------------
    // G, saturated add or reverse subtract
    // ------------------------------------------------

    assign sum_ext  = $signed({a_neg, a_i}) + $signed({b_neg, b_i});
    assign diff_ext = $signed({b_neg, b_i}) - $signed({a_neg, a_i});

    assign func_g = (imm_i == '0) ? sat_lane(sum_ext) : sat_lane(diff_ext);

    // Function select
    always_comb begin
        case (op_i)
            alu_pkg::OP_PL_R:      result_o = func_r;
            alu_pkg::OP_PL_F:      result_o = func_f;
            alu_pkg::OP_PL_DECODE: result_o = func_decode;
            alu_pkg::OP_PL_G:      result_o = func_g;
            default:               result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/alu_shifter.sv
// ------------------------------------------------
// Word shifter built on one right shifter. Left
// shifts reverse the operand before and after.
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module alu_shifter (
    input  wire alu_pkg::alu_op_e op_i,
    input  wire alu_pkg::xlen_t   operand_a_i,
    input  wire alu_pkg::shamt_t  shamt_i,
    output alu_pkg::xlen_t        result_o
);

    logic               shift_left;
    logic               shift_arith;
    alu_pkg::xlen_t     operand_a_rev;
    alu_pkg::xlen_t     shift_in;
    logic [`ALU_XLEN:0] shift_in_ext;
    logic [`ALU_XLEN:0] right_result;
    alu_pkg::xlen_t     left_result;

    assign shift_left  = (op_i == alu_pkg::OP_SLL);
    assign shift_arith = (op_i == alu_pkg::OP_SRA);

    // Bit reversal of the input and of the shifted word
    for (genvar k = 0; k < `ALU_XLEN; k++) begin : g_rev
        assign operand_a_rev[k] = operand_a_i[`ALU_XLEN-1-k];
        assign left_result[k]   = right_result[`ALU_XLEN-1-k];
    end

    assign shift_in = shift_left ? operand_a_rev : operand_a_i;

    // Extra top bit is the fill value
    assign shift_in_ext = {shift_arith & shift_in[`ALU_XLEN-1], shift_in};

    assign right_result = $unsigned($signed(shift_in_ext) >>> shamt_i);

    always_comb begin
        if (shift_left) begin
            result_o = left_result;
        end else begin
            result_o = right_result[`ALU_XLEN-1:0];
        end
    end

endmodule

`default_nettype wire

// File: logic/alu_arith.sv
// ------------------------------------------------
// Adder, magnitude compare and branch resolution.
// Purely combinational, used inside alu_top.
// ------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module alu_arith (
    input  wire alu_pkg::alu_op_e op_i,
    input  wire alu_pkg::xlen_t   operand_a_i,
    input  wire alu_pkg::xlen_t   operand_b_i,
    output alu_pkg::xlen_t        sum_o,
    output logic                  less_o,
    output logic                  branch_o
);

    logic               negate_b;
    logic [`ALU_XLEN:0] adder_in_a;
    logic [`ALU_XLEN:0] adder_in_b;
    logic [`ALU_XLEN:0] adder_ext;
    logic               zero_flag;
    logic               signed_cmp;

    // Subtract for SUB and for the equality branches
    always_comb begin
        case (op_i)
            alu_pkg::OP_SUB, alu_pkg::OP_EQ, alu_pkg::OP_NE: negate_b = 1'b1;
            default:                                         negate_b = 1'b0;
        endcase
    end

    // Extra low bit pair carries the +1 of the two's complement
    assign adder_in_a = {operand_a_i, 1'b1};
    assign adder_in_b = {operand_b_i, 1'b0} ^ {(`ALU_XLEN+1){negate_b}};
    assign adder_ext  = adder_in_a + adder_in_b;
    assign sum_o      = adder_ext[`ALU_XLEN:1];
    assign zero_flag  = ~|sum_o;

    // Sign extension only for the signed compares
    assign signed_cmp = (op_i == alu_pkg::OP_SLTS) || (op_i == alu_pkg::OP_LTS) ||
                        (op_i == alu_pkg::OP_GES);

    assign less_o = $signed({signed_cmp & operand_a_i[`ALU_XLEN-1], operand_a_i}) <
                    $signed({signed_cmp & operand_b_i[`ALU_XLEN-1], operand_b_i});

    always_comb begin
        case (op_i)
            alu_pkg::OP_EQ:                  branch_o = zero_flag;
            alu_pkg::OP_NE:                  branch_o = ~zero_flag;
            alu_pkg::OP_LTS, alu_pkg::OP_LTU: branch_o = less_o;
            alu_pkg::OP_GES, alu_pkg::OP_GEU: branch_o = ~less_o;
            default:                         branch_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/alu_pkg.sv
// ------------------------------------------------
// Shared types of the ALU: data word, polar lane,
// shift amount and the operation code.
// ------------------------------------------------

`default_nettype none

`include "alu_defs.svh"

package alu_pkg;

    // Data word and polar lane
    typedef logic [`ALU_XLEN-1:0] xlen_t;
    typedef logic [`POLAR_Q-1:0]  lane_t;

    // Low bits of operand b used as shift amount
    typedef logic [$clog2(`ALU_XLEN)-1:0] shamt_t;

    typedef enum logic [4:0] {
        // Adder
        OP_ADD       = 5'd0,
        OP_SUB       = 5'd1,
        // Bitwise logic
        OP_AND       = 5'd2,
        OP_OR        = 5'd3,
        OP_XOR       = 5'd4,
        // Shifts
        OP_SLL       = 5'd5,
        OP_SRL       = 5'd6,
        OP_SRA       = 5'd7,
        // Set less than
        OP_SLTS      = 5'd8,
        OP_SLTU      = 5'd9,
        // Branch conditions
        OP_EQ        = 5'd10,
        OP_NE        = 5'd11,
        OP_LTS       = 5'd12,
        OP_LTU       = 5'd13,
        OP_GES       = 5'd14,
        OP_GEU       = 5'd15,
        // Polar SIMD lane functions
        OP_PL_R      = 5'd16,
        OP_PL_F      = 5'd17,
        OP_PL_DECODE = 5'd18,
        OP_PL_G      = 5'd19
    } alu_op_e;

endpackage

`default_nettype wire

// File: logic/alu_defs.svh
// ------------------------------------------------
// Width macros for the registered integer ALU.
// Include wherever the word or lane sizes are needed.
// ------------------------------------------------

`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Data word width, one RV32 register
`define ALU_XLEN 32

// Width of one polar SIMD lane
`define POLAR_Q 8

// Lanes per word, ALU_XLEN / POLAR_Q
`define POLAR_LANES 4

`endif
